//--- st_io_block.f
logic/link_pkg.sv
logic/regmap_pkg.sv
logic/packet_sender.sv
logic/rx_history.sv
logic/latency_timer.sv
logic/link_channel.sv
logic/io_regs.sv
logic/st_io_block.sv
testbench/st_io_block_tb.sv

//--- Makefile
TOP = st_io_block_tb

.PHONY: compile run clean

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f st_io_block.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

//--- testbench/st_io_block_tb.sv
module st_io_block_tb;
	import link_pkg::*;
	import regmap_pkg::*;

	// six tests of at most about 300 cycles each plus margin
	localparam int max_cycles = 4000;
	localparam int rec_depth = 64;

	logic io_clk = 1'b0;
	logic rst;
	logic io_sel;
	logic io_sync;
	logic [addr_width-1:0] io_addr;
	logic io_rd_en;
	logic io_wr_en;
	logic [bus_width-1:0] io_wr_data;
	logic [bus_width-1:0] io_rd_data;
	logic io_rd_ack;
	logic [stream_width-1:0] tx_data_1;
	logic [stream_width-1:0] tx_data_2;
	logic tx_valid_1;
	logic tx_valid_2;
	logic tx_last_1;
	logic tx_last_2;
	logic [keep_width-1:0] tx_keep_1;
	logic [keep_width-1:0] tx_keep_2;
	logic tx_ready_1;
	logic tx_ready_2;
	// receive side belongs to the link model
	logic [stream_width-1:0] rx_data_1 = '0;
	logic [stream_width-1:0] rx_data_2 = '0;
	logic rx_valid_1 = 1'b0;
	logic rx_valid_2 = 1'b0;
	logic rx_last_1 = 1'b0;
	logic rx_last_2 = 1'b0;
	logic [keep_width-1:0] rx_keep_1 = '0;
	logic [keep_width-1:0] rx_keep_2 = '0;
	logic hard_err_1;
	logic hard_err_2;
	logic soft_err_1;
	logic soft_err_2;
	logic frame_err_1;
	logic frame_err_2;
	logic lane_up_1;
	logic lane_up_2;
	logic channel_up_1;
	logic channel_up_2;

	// stimulus and model state
	logic [31:0] lfsr_state = 32'hf928;
	int link_delay = 1;
	logic [19:0] line_12 [8];
	logic [19:0] line_21 [8];
	int rx_cnt [2] = '{0, 0};
	logic [5:0] rx_pins [2][rec_depth];
	logic [15:0] pkt_model [2][packet_words];
	logic [15:0] sent_words [2][rec_depth];
	int sent_cnt [2];
	logic [1:0] en_model;
	logic sr_model;
	logic [31:0] lat_model [2];
	string test_name = "reset";
	int value_errors = 0;
	int other_errors = 0;
	int cycle_cnt = 0;
	logic rd_expect_ack = 1'b0;
	logic [addr_width-1:0] rd_addr_q = '0;
	logic [31:0] exp_word;

	st_io_block dut (.*);

	always #50 io_clk = ~io_clk;

	//////////////////////////////////////////////////
	// random source and reference model
	//////////////////////////////////////////////////
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	// one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	// pins are {tx_ready, hard, soft, frame, lane, channel_up}
	function automatic logic [31:0] pack_status(input logic [5:0] pins, input logic last);
		logic [31:0] w;
		w = '0;
		w[4:0] = pins[4:0];
		// keep is always all ones on this link
		w[6:5] = 2'b11;
		w[9] = last;
		w[10] = 1'b1;
		w[11] = pins[5];
		return w;
	endfunction

	// slot 0 oldest and slot 2 newest
	function automatic logic [31:0] hist_word(input int m, input int s, input bit status);
		int j;
		j = rx_cnt[m] - history_depth + s;
		if (j < 0) begin
			return '0;
		end
		if (status) begin
			return pack_status(rx_pins[m][j], (j % packet_words) == packet_words - 1);
		end
		// channel m receives what the other one sent
		return {16'h0, sent_words[1 - m][j]};
	endfunction

	function automatic logic [31:0] expected_read(input logic [addr_width-1:0] addr);
		logic [31:0] word;
		int off;
		word = '0;
		if (addr == addr_latency_1to2) begin
			word = lat_model[0];
		end else if (addr == addr_latency_2to1) begin
			word = lat_model[1];
		end else if (addr == addr_enable) begin
			word = {30'h0, en_model};
		end else if (addr == addr_sender_reset) begin
			word = {31'h0, sr_model};
		end else begin
			for (int c = 0; c < 2; c++) begin
				off = int'(addr) - int'((c == 0) ? chan1_base : chan2_base);
				if (off >= 0 && off < 3) begin
					word = {16'h0, pkt_model[c][off]};
				end else if (off >= 3 && off < 6) begin
					word = hist_word(c, off - 3, 1'b0);
				end else if (off >= 6 && off < 9) begin
					word = hist_word(c, off - 6, 1'b1);
				end
			end
		end
		return word;
	endfunction

	//////////////////////////////////////////////////
	// link model from tx of one channel to rx of the other
	//////////////////////////////////////////////////
	always @(posedge io_clk) begin
		if (rst) begin
			for (int i = 0; i < 8; i++) begin
				line_12[i] = '0;
				line_21[i] = '0;
			end
			rx_cnt[0] <= 0;
			rx_cnt[1] <= 0;
		end else begin
			for (int i = 7; i > 0; i--) begin
				line_12[i] = line_12[i-1];
				line_21[i] = line_21[i-1];
			end
			// a beat only when valid meets ready
			line_12[0] = {tx_valid_1 && tx_ready_1, tx_last_1, tx_keep_1, tx_data_1};
			line_21[0] = {tx_valid_2 && tx_ready_2, tx_last_2, tx_keep_2, tx_data_2};
			// what the dut samples along with each received word
			if (rx_valid_1 && rx_cnt[0] < rec_depth) begin
				rx_pins[0][rx_cnt[0]] <= {tx_ready_1, hard_err_1, soft_err_1, frame_err_1,
					lane_up_1, channel_up_1};
				rx_cnt[0] <= rx_cnt[0] + 1;
			end
			if (rx_valid_2 && rx_cnt[1] < rec_depth) begin
				rx_pins[1][rx_cnt[1]] <= {tx_ready_2, hard_err_2, soft_err_2, frame_err_2,
					lane_up_2, channel_up_2};
				rx_cnt[1] <= rx_cnt[1] + 1;
			end
		end
		{rx_valid_2, rx_last_2, rx_keep_2, rx_data_2} <= line_12[link_delay-1];
		{rx_valid_1, rx_last_1, rx_keep_1, rx_data_1} <= line_21[link_delay-1];
	end

	//////////////////////////////////////////////////
	// compare process
	//////////////////////////////////////////////////
	always @(posedge io_clk) begin
		rd_expect_ack <= !rst && io_sel && io_rd_en && io_sync;
		rd_addr_q <= io_addr;
	end

	// sampled mid-cycle between edges
	always @(negedge io_clk) begin
		if (!rst) begin
			assert (io_rd_ack == rd_expect_ack) else begin
				other_errors++;
				$display("read acknowledge %s for address %h in test %s",
					rd_expect_ack ? "missing" : "unexpected", rd_addr_q, test_name);
			end
			if (rd_expect_ack) begin
				exp_word = expected_read(rd_addr_q);
				assert (io_rd_data === exp_word) else begin
					value_errors++;
					$display("[ERROR] %s addr %h expected %h actual %h",
						test_name, rd_addr_q, exp_word, io_rd_data);
				end
			end
		end
	end

	// run limit
	always @(posedge io_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= max_cycles) begin
			$display("timeout, run stopped after %0d cycles", cycle_cnt);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// bus and link tasks
	//////////////////////////////////////////////////
	task automatic bus_write(input logic [addr_width-1:0] addr, input logic [31:0] data);
		int off;
		@(posedge io_clk);
		io_sel <= 1'b1;
		io_wr_en <= 1'b1;
		io_addr <= addr;
		io_wr_data <= data;
		@(posedge io_clk);
		io_sel <= 1'b0;
		io_wr_en <= 1'b0;
		// mirror into the model
		if (addr == addr_enable) begin
			en_model = data[1:0];
		end
		if (addr == addr_sender_reset) begin
			sr_model = data[0];
			if (data[0]) begin
				lat_model[0] = '0;
				lat_model[1] = '0;
			end
		end
		for (int c = 0; c < 2; c++) begin
			off = int'(addr) - int'((c == 0) ? chan1_base : chan2_base);
			if (off >= 0 && off < packet_words) begin
				pkt_model[c][off] = data[15:0];
			end
		end
	endtask

	// single cycle read strobe with optional sync
	task automatic bus_read(input logic [addr_width-1:0] addr, input logic sync);
		@(posedge io_clk);
		io_sel <= 1'b1;
		io_rd_en <= 1'b1;
		io_sync <= sync;
		io_addr <= addr;
		@(posedge io_clk);
		io_sel <= 1'b0;
		io_rd_en <= 1'b0;
		io_sync <= 1'b0;
	endtask

	task automatic read_block(input int c, input int first_off, input int last_off);
		logic [addr_width-1:0] base;
		base = (c == 0) ? chan1_base : chan2_base;
		for (int off = first_off; off <= last_off; off++) begin
			bus_read(base + 16'(off), 1'b1);
		end
	endtask

	task automatic write_packets();
		logic [addr_width-1:0] base;
		for (int c = 0; c < 2; c++) begin
			base = (c == 0) ? chan1_base : chan2_base;
			for (int w = 0; w < packet_words; w++) begin
				bus_write(base + 16'(w), rand_bits(32));
			end
		end
	endtask

	task automatic drive_pins(input bit random_ready);
		logic [31:0] r;
		r = rand_bits(10);
		{hard_err_1, soft_err_1, frame_err_1, lane_up_1, channel_up_1} <= r[4:0];
		{hard_err_2, soft_err_2, frame_err_2, lane_up_2, channel_up_2} <= r[9:5];
		if (random_ready) begin
			r = rand_bits(2);
			tx_ready_1 <= r[0];
			tx_ready_2 <= r[1];
		end else begin
			tx_ready_1 <= 1'b1;
			tx_ready_2 <= 1'b1;
		end
	endtask

	// enable both senders and wait for both packets to land
	task automatic run_packets(input bit random_ready);
		int base_cnt [2];
		@(negedge io_clk);
		link_delay = 1 + int'(rand_bits(3));
		for (int c = 0; c < 2; c++) begin
			base_cnt[c] = rx_cnt[c];
			for (int w = 0; w < packet_words; w++) begin
				sent_words[c][sent_cnt[c]] = pkt_model[c][w];
				sent_cnt[c]++;
			end
		end
		bus_write(addr_enable, 32'h3);
		while (rx_cnt[0] < base_cnt[0] + packet_words
				|| rx_cnt[1] < base_cnt[1] + packet_words) begin
			@(posedge io_clk);
			drive_pins(random_ready);
		end
		// drain the delay line so duplicates would show up
		repeat (12) begin
			@(posedge io_clk);
			tx_ready_1 <= 1'b1;
			tx_ready_2 <= 1'b1;
		end
		for (int m = 0; m < 2; m++) begin
			assert (rx_cnt[m] == base_cnt[m] + packet_words) else begin
				other_errors++;
				$display("channel %0d received %0d words in test %s instead of %0d",
					m + 1, rx_cnt[m] - base_cnt[m], test_name, packet_words);
			end
		end
		if (!random_ready) begin
			lat_model[0] = link_delay;
			lat_model[1] = link_delay;
		end
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////
	initial begin
		rst = 1'b1;
		io_sel = 1'b0;
		io_sync = 1'b0;
		io_addr = '0;
		io_rd_en = 1'b0;
		io_wr_en = 1'b0;
		io_wr_data = '0;
		tx_ready_1 = 1'b1;
		tx_ready_2 = 1'b1;
		{hard_err_1, soft_err_1, frame_err_1, lane_up_1, channel_up_1} = '0;
		{hard_err_2, soft_err_2, frame_err_2, lane_up_2, channel_up_2} = '0;
		en_model = '0;
		sr_model = 1'b0;
		lat_model[0] = '0;
		lat_model[1] = '0;
		for (int c = 0; c < 2; c++) begin
			sent_cnt[c] = 0;
			for (int w = 0; w < packet_words; w++) begin
				pkt_model[c][w] = '0;
			end
		end
		repeat (16) @(posedge io_clk);
		rst <= 1'b0;

		// senders held off while enable is poked
		test_name = "register_readback";
		bus_write(addr_sender_reset, 32'h1);
		write_packets();
		bus_write(addr_enable, rand_bits(32));
		bus_read(addr_enable, 1'b1);
		bus_read(addr_sender_reset, 1'b1);
		read_block(0, 0, 8);
		read_block(1, 0, 8);
		bus_read(addr_latency_1to2, 1'b1);
		bus_read(addr_latency_2to1, 1'b1);
		// each unmapped read follows a nonzero packet word
		bus_read(chan1_base, 1'b1);
		bus_read(16'h0000, 1'b1);
		bus_read(chan1_base + 16'h0002, 1'b1);
		bus_read(16'h002a, 1'b1);
		bus_read(chan2_base, 1'b1);
		bus_read(16'h003a, 1'b1);
		bus_read(chan2_base + 16'h0002, 1'b1);
		bus_read(16'hffff, 1'b1);
		// read without sync gets no ack
		bus_read(addr_enable, 1'b0);
		bus_write(addr_enable, 32'h0);
		bus_write(addr_sender_reset, 32'h0);
		bus_read(addr_enable, 1'b1);
		bus_read(addr_sender_reset, 1'b1);

		test_name = "rx_words";
		run_packets(1'b0);
		read_block(0, 3, 5);
		read_block(1, 3, 5);

		test_name = "rx_status";
		read_block(0, 6, 8);
		read_block(1, 6, 8);

		test_name = "latency";
		bus_read(addr_latency_1to2, 1'b1);
		bus_read(addr_latency_2to1, 1'b1);

		test_name = "ready_gaps";
		bus_write(addr_sender_reset, 32'h1);
		bus_write(addr_enable, 32'h0);
		bus_write(addr_sender_reset, 32'h0);
		write_packets();
		run_packets(1'b1);
		read_block(0, 3, 8);
		read_block(1, 3, 8);

		// enable dropped before release so nothing restarts early
		test_name = "sender_reset";
		bus_write(addr_sender_reset, 32'h1);
		bus_write(addr_enable, 32'h0);
		bus_read(addr_latency_1to2, 1'b1);
		bus_read(addr_latency_2to1, 1'b1);
		bus_write(addr_sender_reset, 32'h0);
		bus_read(addr_latency_1to2, 1'b1);
		bus_read(addr_latency_2to1, 1'b1);
		write_packets();
		run_packets(1'b0);
		read_block(0, 3, 8);
		read_block(1, 3, 8);
		bus_read(addr_latency_1to2, 1'b1);
		bus_read(addr_latency_2to1, 1'b1);

		repeat (4) @(posedge io_clk);
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- logic/st_io_block.sv
module st_io_block (
	input  logic io_clk,
	input  logic rst,
	// register bus
	input  logic io_sel,
	input  logic io_sync,
	input  logic [regmap_pkg::addr_width-1:0] io_addr,
	input  logic io_rd_en,
	input  logic io_wr_en,
	input  logic [link_pkg::bus_width-1:0] io_wr_data,
	output logic [link_pkg::bus_width-1:0] io_rd_data,
	output logic io_rd_ack,
	// channel 1 link side
	output logic [link_pkg::stream_width-1:0] tx_data_1,
	output logic tx_valid_1,
	output logic tx_last_1,
	output logic [link_pkg::keep_width-1:0] tx_keep_1,
	input  logic tx_ready_1,
	input  logic [link_pkg::stream_width-1:0] rx_data_1,
	input  logic rx_valid_1,
	input  logic rx_last_1,
	input  logic [link_pkg::keep_width-1:0] rx_keep_1,
	input  logic hard_err_1,
	input  logic soft_err_1,
	input  logic frame_err_1,
	input  logic lane_up_1,
	input  logic channel_up_1,
	// channel 2 link side
	output logic [link_pkg::stream_width-1:0] tx_data_2,
	output logic tx_valid_2,
	output logic tx_last_2,
	output logic [link_pkg::keep_width-1:0] tx_keep_2,
	input  logic tx_ready_2,
	input  logic [link_pkg::stream_width-1:0] rx_data_2,
	input  logic rx_valid_2,
	input  logic rx_last_2,
	input  logic [link_pkg::keep_width-1:0] rx_keep_2,
	input  logic hard_err_2,
	input  logic soft_err_2,
	input  logic frame_err_2,
	input  logic lane_up_2,
	input  logic channel_up_2
);
	import link_pkg::*;
	import regmap_pkg::*;

	logic [1:0] enable;
	logic sender_reset;
	logic chan1_hit;
	logic chan2_hit;
	logic [bus_width-1:0] chan1_word;
	logic [bus_width-1:0] chan2_word;
	logic [bus_width-1:0] latency_1to2;
	logic [bus_width-1:0] latency_2to1;

	//////////////////////////////////////////////////
	// bus front end
	//////////////////////////////////////////////////
	io_regs u_regs (
		.io_clk      (io_clk),
		.rst         (rst),
		.io_sel      (io_sel),
		.io_sync     (io_sync),
		.io_addr     (io_addr),
		.io_rd_en    (io_rd_en),
		.io_wr_en    (io_wr_en),
		.io_wr_data  (io_wr_data),
		.io_rd_data  (io_rd_data),
		.io_rd_ack   (io_rd_ack),
		.enable      (enable),
		.sender_reset(sender_reset),
		.chan1_hit   (chan1_hit),
		.chan2_hit   (chan2_hit),
		.chan1_word  (chan1_word),
		.chan2_word  (chan2_word),
		.latency_1to2(latency_1to2),
		.latency_2to1(latency_2to1)
	);

	//////////////////////////////////////////////////
	// channels
	//////////////////////////////////////////////////
	link_channel #(.base_addr(chan1_base)) u_chan_1 (
		.io_clk      (io_clk),
		.rst         (rst),
		.sender_reset(sender_reset),
		.enable      (enable[0]),
		.io_sel      (io_sel),
		.io_wr_en    (io_wr_en),
		.io_addr     (io_addr),
		.io_wr_data  (io_wr_data),
		.rd_hit      (chan1_hit),
		.rd_word     (chan1_word),
		.tx_data     (tx_data_1),
		.tx_valid    (tx_valid_1),
		.tx_last     (tx_last_1),
		.tx_keep     (tx_keep_1),
		.tx_ready    (tx_ready_1),
		.rx_data     (rx_data_1),
		.rx_valid    (rx_valid_1),
		.rx_last     (rx_last_1),
		.rx_keep     (rx_keep_1),
		.hard_err    (hard_err_1),
		.soft_err    (soft_err_1),
		.frame_err   (frame_err_1),
		.lane_up     (lane_up_1),
		.channel_up  (channel_up_1)
	);

	link_channel #(.base_addr(chan2_base)) u_chan_2 (
		.io_clk      (io_clk),
		.rst         (rst),
		.sender_reset(sender_reset),
		.enable      (enable[1]),
		.io_sel      (io_sel),
		.io_wr_en    (io_wr_en),
		.io_addr     (io_addr),
		.io_wr_data  (io_wr_data),
		.rd_hit      (chan2_hit),
		.rd_word     (chan2_word),
		.tx_data     (tx_data_2),
		.tx_valid    (tx_valid_2),
		.tx_last     (tx_last_2),
		.tx_keep     (tx_keep_2),
		.tx_ready    (tx_ready_2),
		.rx_data     (rx_data_2),
		.rx_valid    (rx_valid_2),
		.rx_last     (rx_last_2),
		.rx_keep     (rx_keep_2),
		.hard_err    (hard_err_2),
		.soft_err    (soft_err_2),
		.frame_err   (frame_err_2),
		.lane_up     (lane_up_2),
		.channel_up  (channel_up_2)
	);

	// first send on one side to first receive on the other
	latency_timer timer_1to2 (
		.io_clk      (io_clk),
		.rst         (rst),
		.sender_reset(sender_reset),
		.start_strobe(tx_valid_1),
		.stop_strobe (rx_valid_2),
		.latency     (latency_1to2)
	);

	latency_timer timer_2to1 (
		.io_clk      (io_clk),
		.rst         (rst),
		.sender_reset(sender_reset),
		.start_strobe(tx_valid_2),
		.stop_strobe (rx_valid_1),
		.latency     (latency_2to1)
	);

endmodule

//--- logic/io_regs.sv
module io_regs (
	input  logic io_clk,
	input  logic rst,
	// register bus
	input  logic io_sel,
	input  logic io_sync,
	input  logic [regmap_pkg::addr_width-1:0] io_addr,
	input  logic io_rd_en,
	input  logic io_wr_en,
	input  logic [link_pkg::bus_width-1:0] io_wr_data,
	output logic [link_pkg::bus_width-1:0] io_rd_data,
	output logic io_rd_ack,
	// control out to channels and timers
	output logic [1:0] enable,
	output logic sender_reset,
	// readback sources
	input  logic chan1_hit,
	input  logic chan2_hit,
	input  logic [link_pkg::bus_width-1:0] chan1_word,
	input  logic [link_pkg::bus_width-1:0] chan2_word,
	input  logic [link_pkg::bus_width-1:0] latency_1to2,
	input  logic [link_pkg::bus_width-1:0] latency_2to1
);
	import link_pkg::*;
	import regmap_pkg::*;

	logic wr_strobe;
	logic rd_strobe;
	logic [bus_width-1:0] rd_next;

	assign wr_strobe = io_sel && io_wr_en;
	assign rd_strobe = io_sel && io_rd_en;

	//////////////////////////////////////////////////
	// control registers
	//////////////////////////////////////////////////
	always_ff @(posedge io_clk) begin
		if (rst) begin
			enable <= '0;
			sender_reset <= 1'b0;
		end else if (wr_strobe) begin
			if (io_addr == addr_enable) begin
				enable <= io_wr_data[1:0];
			end
			// software writes 1 then 0 for a pulse
			if (io_addr == addr_sender_reset) begin
				sender_reset <= io_wr_data[0];
			end
		end
	end

	// read select, unmapped reads zero
	always_comb begin
		if (chan1_hit) begin
			rd_next = chan1_word;
		end else if (chan2_hit) begin
			rd_next = chan2_word;
		end else begin
			case (io_addr)
				addr_latency_1to2: rd_next = latency_1to2;
				addr_latency_2to1: rd_next = latency_2to1;
				addr_enable: rd_next = {{(bus_width - 2){1'b0}}, enable};
				addr_sender_reset: rd_next = {{(bus_width - 1){1'b0}}, sender_reset};
				default: rd_next = '0;
			endcase
		end
	end

	// one cycle read latency
	always_ff @(posedge io_clk) begin
		if (rd_strobe) begin
			io_rd_data <= rd_next;
		end
	end

	// ack only on a synced read
	always_ff @(posedge io_clk) begin
		if (rst) begin
			io_rd_ack <= 1'b0;
		end else begin
			io_rd_ack <= io_sync && rd_strobe;
		end
	end

endmodule

//--- logic/link_channel.sv
module link_channel #(
	parameter logic [regmap_pkg::addr_width-1:0] base_addr = regmap_pkg::chan1_base
) (
	input  logic io_clk,
	input  logic rst,
	input  logic sender_reset,
	input  logic enable,
	input  logic io_sel,
	input  logic io_wr_en,
	input  logic [regmap_pkg::addr_width-1:0] io_addr,
	input  logic [link_pkg::bus_width-1:0] io_wr_data,
	output logic rd_hit,
	output logic [link_pkg::bus_width-1:0] rd_word,
	// transmit stream
	output logic [link_pkg::stream_width-1:0] tx_data,
	output logic tx_valid,
	output logic tx_last,
	output logic [link_pkg::keep_width-1:0] tx_keep,
	input  logic tx_ready,
	// receive stream, no ready
	input  logic [link_pkg::stream_width-1:0] rx_data,
	input  logic rx_valid,
	input  logic rx_last,
	input  logic [link_pkg::keep_width-1:0] rx_keep,
	// link status pins
	input  logic hard_err,
	input  logic soft_err,
	input  logic frame_err,
	input  logic lane_up,
	input  logic channel_up
);
	import link_pkg::*;
	import regmap_pkg::*;

	logic [addr_width-1:0] offset;
	logic [addr_width-1:0] data_rel;
	logic [addr_width-1:0] stat_rel;
	logic [stream_width-1:0] pkt [packet_words];
	logic [history_depth-1:0][bus_width-1:0] rx_words;
	link_status_word_u [history_depth-1:0] rx_status;

	//////////////////////////////////////////////////
	// block decode, one compare for all nine regs
	//////////////////////////////////////////////////
	assign offset = io_addr - base_addr;
	assign rd_hit = (io_addr >= base_addr) && (offset < block_size);
	assign data_rel = offset - off_rx_data;
	assign stat_rel = offset - off_rx_status;

	// packet words, low half of the bus word
	always_ff @(posedge io_clk) begin
		if (rst) begin
			for (int i = 0; i < packet_words; i++) begin
				pkt[i] <= '0;
			end
		end else if (io_sel && io_wr_en && rd_hit && (offset < off_rx_data)) begin
			pkt[offset[1:0] - off_packet[1:0]] <= io_wr_data[stream_width-1:0];
		end
	end

	// readback source, registered upstream
	always_comb begin
		if (!rd_hit) begin
			rd_word = '0;
		end else if (offset < off_rx_data) begin
			rd_word = {{(bus_width - stream_width){1'b0}}, pkt[offset[1:0] - off_packet[1:0]]};
		end else if (offset < off_rx_status) begin
			rd_word = rx_words[data_rel[1:0]];
		end else begin
			rd_word = rx_status[stat_rel[1:0]].raw;
		end
	end

	packet_sender u_sender (
		.io_clk      (io_clk),
		.rst         (rst),
		.sender_reset(sender_reset),
		.enable      (enable),
		.word0       (pkt[0]),
		.word1       (pkt[1]),
		.word2       (pkt[2]),
		.tx_ready    (tx_ready),
		.tx_data     (tx_data),
		.tx_valid    (tx_valid),
		.tx_last     (tx_last),
		.tx_keep     (tx_keep)
	);

	// tx_ready snapshot shows back-pressure at receive time
	rx_history u_history (
		.io_clk    (io_clk),
		.rst       (rst),
		.rx_valid  (rx_valid),
		.rx_last   (rx_last),
		.tx_ready  (tx_ready),
		.rx_data   (rx_data),
		.rx_keep   (rx_keep),
		.hard_err  (hard_err),
		.soft_err  (soft_err),
		.frame_err (frame_err),
		.lane_up   (lane_up),
		.channel_up(channel_up),
		.rx_words  (rx_words),
		.rx_status (rx_status)
	);

endmodule

//--- logic/latency_timer.sv
module latency_timer (
	input  logic io_clk,
	input  logic rst,
	input  logic sender_reset,
	input  logic start_strobe,
	input  logic stop_strobe,
	output logic [link_pkg::bus_width-1:0] latency
);

	// armed after first start, stopped after first stop
	logic armed;
	logic stopped;

	always_ff @(posedge io_clk) begin
		if (rst || sender_reset) begin
			armed <= 1'b0;
			stopped <= 1'b0;
			latency <= '0;
		end else if (!armed) begin
			if (start_strobe) begin
				armed <= 1'b1;
				// same cycle start and stop reads zero
				if (stop_strobe) begin
					stopped <= 1'b1;
				end else begin
					latency <= 1;
				end
			end
		end else if (!stopped) begin
			if (stop_strobe) begin
				stopped <= 1'b1;
			end else if (latency != '1) begin
				// saturate instead of wrapping
				latency <= latency + 1'b1;
			end
		end
	end

endmodule

//--- logic/rx_history.sv
module rx_history (
	input  logic io_clk,
	input  logic rst,
	input  logic rx_valid,
	input  logic rx_last,
	input  logic tx_ready,
	input  logic [link_pkg::stream_width-1:0] rx_data,
	input  logic [link_pkg::keep_width-1:0] rx_keep,
	input  logic hard_err,
	input  logic soft_err,
	input  logic frame_err,
	input  logic lane_up,
	input  logic channel_up,
	output logic [link_pkg::history_depth-1:0][link_pkg::bus_width-1:0] rx_words,
	output link_pkg::link_status_word_u [link_pkg::history_depth-1:0] rx_status
);
	import link_pkg::*;

	link_status_word_u snap;

	// status of the word being received
	always_comb begin
		snap.raw = '0;
		snap.fields.channel_up = channel_up;
		snap.fields.lane_up = lane_up;
		snap.fields.frame_err = frame_err;
		snap.fields.soft_err = soft_err;
		snap.fields.hard_err = hard_err;
		snap.fields.rx_keep = rx_keep;
		snap.fields.rx_last = rx_last;
		snap.fields.rx_valid = rx_valid;
		snap.fields.tx_ready = tx_ready;
	end

	//////////////////////////////////////////////////
	// shift history, newest in the top slot
	//////////////////////////////////////////////////
	always_ff @(posedge io_clk) begin
		if (rst) begin
			rx_words <= '0;
			rx_status <= '0;
		end else if (rx_valid) begin
			// older slots move down by one
			for (int i = 0; i < history_depth - 1; i++) begin
				rx_words[i] <= rx_words[i+1];
				rx_status[i] <= rx_status[i+1];
			end
			rx_words[history_depth-1] <= {{(bus_width - stream_width){1'b0}}, rx_data};
			rx_status[history_depth-1] <= snap;
		end
	end

endmodule

//--- logic/packet_sender.sv
module packet_sender (
	input  logic io_clk,
	input  logic rst,
	input  logic sender_reset,
	input  logic enable,
	input  logic [link_pkg::stream_width-1:0] word0,
	input  logic [link_pkg::stream_width-1:0] word1,
	input  logic [link_pkg::stream_width-1:0] word2,
	input  logic tx_ready,
	output logic [link_pkg::stream_width-1:0] tx_data,
	output logic tx_valid,
	output logic tx_last,
	output logic [link_pkg::keep_width-1:0] tx_keep
);
	import link_pkg::*;

	// fsm states
	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_send = 2'd1;
	localparam logic [1:0] st_done = 2'd2;
	localparam logic [1:0] last_idx = 2'(packet_words - 1);

	logic [1:0] state;
	logic [1:0] word_idx;
	logic start;
	logic [stream_width-1:0] pkt_buf [packet_words];

	// enable seen while idle
	assign start = (state == st_idle) && enable && !sender_reset;

	always_ff @(posedge io_clk) begin
		if (rst || sender_reset) begin
			state <= st_idle;
			word_idx <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (start) begin
						state <= st_send;
						word_idx <= '0;
					end
				end
				// advance only when the word is taken
				st_send: begin
					if (tx_ready) begin
						if (word_idx == last_idx) begin
							state <= st_done;
						end else begin
							word_idx <= word_idx + 2'd1;
						end
					end
				end
				// one packet per enable
				st_done: begin
					if (!enable) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// words frozen for the whole packet
	always_ff @(posedge io_clk) begin
		if (start) begin
			pkt_buf[0] <= word0;
			pkt_buf[1] <= word1;
			pkt_buf[2] <= word2;
		end
	end

	// held under back-pressure since idx only moves on tx_ready
	assign tx_valid = (state == st_send);
	assign tx_last = tx_valid && (word_idx == last_idx);
	assign tx_data = pkt_buf[word_idx];
	// every byte valid
	assign tx_keep = '1;

endmodule

//--- logic/regmap_pkg.sv
package regmap_pkg;

	//////////////////////////////////////////////////
	// register bus address map
	//////////////////////////////////////////////////

	// low half of the bus address, upper half decoded upstream
	localparam int addr_width = 16;

	// latency readback, one per direction
	localparam logic [addr_width-1:0] addr_latency_1to2 = 16'h0013;
	localparam logic [addr_width-1:0] addr_latency_2to1 = 16'h0014;

	// bit 0 channel 1, bit 1 channel 2
	localparam logic [addr_width-1:0] addr_enable = 16'h0020;
	// bit 0 holds both senders and timers in reset
	localparam logic [addr_width-1:0] addr_sender_reset = 16'h0030;

	// per channel block bases
	localparam logic [addr_width-1:0] chan1_base = 16'h0021;
	localparam logic [addr_width-1:0] chan2_base = 16'h0031;

	// offsets inside a channel block
	localparam logic [addr_width-1:0] off_packet = 16'h0000;
	localparam logic [addr_width-1:0] off_rx_data = 16'h0003;
	localparam logic [addr_width-1:0] off_rx_status = 16'h0006;
	// nine addresses per block
	localparam logic [addr_width-1:0] block_size = 16'h0009;

endpackage

//--- logic/link_pkg.sv
package link_pkg;

	//////////////////////////////////////////////////
	// link stream and register bus sizes
	//////////////////////////////////////////////////

	// user-side stream word
	localparam int stream_width = 16;
	// one keep bit per stream byte
	localparam int keep_width = 2;
	// register bus word
	localparam int bus_width = 32;
	// words sent per packet
	localparam int packet_words = 3;
	// received slots kept for readback
	localparam int history_depth = 3;

	// status snapshot, read raw by the bus or filled through the fields
	// field order is msb first, so channel_up lands on bit 0
	typedef union packed {
		logic [bus_width-1:0] raw;
		struct packed {
			logic [19:0] zero_hi;
			logic tx_ready;
			logic rx_valid;
			logic rx_last;
			logic [1:0] zero_gap;
			logic [keep_width-1:0] rx_keep;
			logic hard_err;
			logic soft_err;
			logic frame_err;
			logic lane_up;
			logic channel_up;
		} fields;
	} link_status_word_u;

endpackage
